//--- verilog/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    typedef enum logic [3:0] {
        LS_SEL_NONE = 4'd0,
        LS_SEL_LB   = 4'd1,
        LS_SEL_LBU  = 4'd2,
        LS_SEL_LH   = 4'd3,
        LS_SEL_LHU  = 4'd4,
        LS_SEL_LW   = 4'd5,
        LS_SEL_SB   = 4'd6,
        LS_SEL_SH   = 4'd7,
        LS_SEL_SW   = 4'd8
    } ls_sel_e;

    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    // Execute-stage bundle entering the memory stage.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_res;      // Also the data address.
        logic [31:0] rt_data;      // Store data.
        logic        ls_ena;
        ls_sel_e     ls_sel;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic        wb_reg_sel;   // 1 selects load data.
        logic [1:0]  w_hilo_ena;   // Bit 1 hi, bit 0 lo.
        logic [31:0] hi_res;
        logic [31:0] lo_res;
    } ex_bundle_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  wen;          // One bit per byte lane.
        logic [31:0] addr;
        logic [31:0] wdata;
    } ram_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic [31:0] w_data;
        logic [1:0]  w_hilo_ena;
        logic [31:0] hi_res;
        logic [31:0] lo_res;
    } wb_bundle_t;

    // One data word seen whole, by halfword or by byte lane.
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;
        logic [3:0][7:0]  bytes;
    } ram_word_u;

endpackage

`default_nettype wire

//--- verilog/ex_mem_reg.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem_reg (
    input  logic                      clk,
    input  logic                      arst_n,
    input  mem_stage_pkg::ex_bundle_t ex,
    output mem_stage_pkg::ex_bundle_t ex_mem
);

    // Kind, offset and pass-through fields meet the RAM data here.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem.pc         <= 32'h0000_0000;
            ex_mem.alu_res    <= 32'h0000_0000;
            ex_mem.rt_data    <= 32'h0000_0000;
            ex_mem.ls_ena     <= 1'b0;
            ex_mem.ls_sel     <= mem_stage_pkg::LS_SEL_NONE;
            ex_mem.w_reg_ena  <= 1'b0;
            ex_mem.w_reg_dst  <= 5'd0;
            ex_mem.wb_reg_sel <= 1'b0;
            ex_mem.w_hilo_ena <= 2'b00;
            ex_mem.hi_res     <= 32'h0000_0000;
            ex_mem.lo_res     <= 32'h0000_0000;
        end else begin
            ex_mem <= ex;                                // New bundle every clock.
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu (
    input  mem_stage_pkg::ex_bundle_t ex,
    input  mem_stage_pkg::ex_bundle_t ex_mem,
    input  logic [31:0]               ram_rdata,
    output mem_stage_pkg::ram_req_t   ram_req,
    output logic [31:0]               mem_r_data
);

    mem_stage_pkg::ram_word_u wr_word;
    mem_stage_pkg::ram_word_u rd_word;
    logic [1:0]               st_off;
    logic [3:0]               st_wen;
    logic [1:0]               ld_off;
    logic [7:0]               ld_byte;
    logic [15:0]              ld_half;
    logic [31:0]              ld_value;

    assign st_off = ex.alu_res[1:0];

    always_comb begin
        wr_word.word = ex.rt_data;
        st_wen       = 4'b0000;
        case (ex.ls_sel)
            mem_stage_pkg::LS_SEL_SB: begin
                wr_word.bytes = {4{ex.rt_data[7:0]}};   // Same byte on every lane.
                st_wen        = 4'b0001 << st_off;
            end
            mem_stage_pkg::LS_SEL_SH: begin
                wr_word.half = {2{ex.rt_data[15:0]}};
                st_wen       = 4'b0011 << {st_off[1], 1'b0};
            end
            mem_stage_pkg::LS_SEL_SW: begin
                st_wen = 4'b1111;
            end
            default: begin
                st_wen = 4'b0000;                        // Loads and no-ops write nothing.
            end
        endcase
    end

    always_comb begin
        ram_req.en    = ex.ls_ena;
        ram_req.wen   = st_wen & {4{ex.ls_ena}};
        ram_req.addr  = ex.alu_res;
        ram_req.wdata = wr_word.word;
    end

    // Memory side lines up with the word returned by the RAM.
    assign rd_word.word = ram_rdata;
    assign ld_off       = ex_mem.alu_res[1:0];
    assign ld_byte      = rd_word.bytes[ld_off];
    assign ld_half      = rd_word.half[ld_off[1]];

    always_comb begin
        case (ex_mem.ls_sel)
            mem_stage_pkg::LS_SEL_LB: begin
                ld_value = {{24{ld_byte[7]}}, ld_byte};
            end
            mem_stage_pkg::LS_SEL_LBU: begin
                ld_value = {24'h000000, ld_byte};
            end
            mem_stage_pkg::LS_SEL_LH: begin
                ld_value = {{16{ld_half[15]}}, ld_half};
            end
            mem_stage_pkg::LS_SEL_LHU: begin
                ld_value = {16'h0000, ld_half};
            end
            mem_stage_pkg::LS_SEL_LW: begin
                ld_value = rd_word.word;
            end
            default: begin
                ld_value = 32'h0000_0000;                // Stores return nothing.
            end
        endcase
    end

    assign mem_r_data = ex_mem.ls_ena ? ld_value : 32'h0000_0000;

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram (
    input  logic                    clk,
    input  mem_stage_pkg::ram_req_t ram_req,
    output logic [31:0]             rdata
);

    logic [31:0]                   mem [mem_stage_pkg::RAM_WORDS];
    logic [mem_stage_pkg::RAM_AW-1:0] idx;

    // Upper address bits are ignored.
    assign idx = ram_req.addr[mem_stage_pkg::RAM_AW+1:2];

    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_req.wen[i]) begin
                    mem[idx][i*8 +: 8] <= ram_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Read data holds while en is low.
    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

//--- verilog/writeback_reg.sv
`timescale 1ns/10ps
`default_nettype none

module writeback_reg (
    input  logic                      clk,
    input  logic                      arst_n,
    input  mem_stage_pkg::ex_bundle_t ex_mem,
    input  logic [31:0]               mem_r_data,
    output mem_stage_pkg::wb_bundle_t wb
);

    mem_stage_pkg::wb_bundle_t wb_next;

    always_comb begin
        wb_next.pc         = ex_mem.pc;
        wb_next.w_reg_ena  = ex_mem.w_reg_ena;
        wb_next.w_reg_dst  = ex_mem.w_reg_dst;
        wb_next.w_data     = ex_mem.wb_reg_sel ? mem_r_data : ex_mem.alu_res;
        wb_next.w_hilo_ena = ex_mem.w_hilo_ena;
        wb_next.hi_res     = ex_mem.hi_res;
        wb_next.lo_res     = ex_mem.lo_res;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;                                    // No write enables.
        end else begin
            wb <= wb_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  mem_stage_pkg::ex_bundle_t ex,
    output mem_stage_pkg::wb_bundle_t wb
);

    mem_stage_pkg::ex_bundle_t ex_mem;
    mem_stage_pkg::ram_req_t   ram_req;
    logic [31:0]               ram_rdata;
    logic [31:0]               mem_r_data;

    ex_mem_reg i_ex_mem_reg (
        .clk    (clk),
        .arst_n (arst_n),
        .ex     (ex),
        .ex_mem (ex_mem)
    );

    // Request from ex, load data back against ex_mem.
    lsu i_lsu (
        .ex         (ex),
        .ex_mem     (ex_mem),
        .ram_rdata  (ram_rdata),
        .ram_req    (ram_req),
        .mem_r_data (mem_r_data)
    );

    data_ram i_data_ram (
        .clk     (clk),
        .ram_req (ram_req),
        .rdata   (ram_rdata)
    );

    writeback_reg i_writeback_reg (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_mem     (ex_mem),
        .mem_r_data (mem_r_data),
        .wb         (wb)
    );

endmodule

`default_nettype wire

//--- dv/mem_stage_assert.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_assert (
    input logic                      clk,
    input logic                      arst_n,
    input mem_stage_pkg::ram_req_t   ram_req,
    input mem_stage_pkg::wb_bundle_t wb
);

    wen_needs_en: assert property (@(posedge clk)
        (ram_req.wen != 4'b0000) |-> ram_req.en)
        else $error("RAM write enables set while en is low");

    // Single byte, halfword or full word only.
    wen_legal: assert property (@(posedge clk)
        ram_req.wen inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                            4'b0011, 4'b1100, 4'b1111})
        else $error("RAM write enable pattern %b is not a legal lane pattern", ram_req.wen);

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> (!wb.w_reg_ena && wb.w_hilo_ena == 2'b00))
        else $error("Writeback enables active while reset is asserted");

endmodule

// RAM side has no reset and no writeback bundle.
bind data_ram mem_stage_assert i_ram_assert (
    .clk     (clk),
    .arst_n  (1'b1),
    .ram_req (ram_req),
    .wb      ('0)
);

bind writeback_reg mem_stage_assert i_wb_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .ram_req ('0),
    .wb      (wb)
);

`default_nettype wire

//--- dv/mem_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_tb;

    localparam int          CLK_HALF    = 4;
    localparam int          RST_CYCLES  = 5;
    localparam int          MAX_OPS     = 128;
    localparam string       GOLDEN_PATH = "dv/mem_stage_golden.txt";
    localparam logic [31:0] PC_BASE     = 32'h0040_0000;
    localparam logic [31:0] LFSR_SEED   = 32'h0000_9346;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    typedef struct packed {
        logic [3:0]  ls_sel;
        logic [31:0] addr;
        logic [31:0] rt_data;
        logic [31:0] alu_res;
        logic [4:0]  w_reg_dst;
        logic        wb_reg_sel;
        logic [1:0]  w_hilo_ena;
        logic [31:0] hi_res;
        logic [31:0] lo_res;
        logic [31:0] w_data;      // Expected write value.
    } golden_op_t;

    typedef struct packed {
        logic        idle;        // Only the enables are checked.
        logic [31:0] pc;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic [31:0] w_data;
        logic [1:0]  w_hilo_ena;
        logic [31:0] hi_res;
        logic [31:0] lo_res;
    } expect_t;

    logic                      clk;
    logic                      arst_n;
    mem_stage_pkg::ex_bundle_t ex;
    mem_stage_pkg::wb_bundle_t wb;

    golden_op_t  ops [MAX_OPS];
    int          n_ops;
    expect_t     exp_q [$];
    logic [31:0] lfsr_state;
    logic        run_started;
    int          chk_cnt;
    int          ops_checked;
    int          err_cnt;
    int          other_err_cnt;

    mem_stage i_mem_stage (
        .clk    (clk),
        .arst_n (arst_n),
        .ex     (ex),
        .wb     (wb)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

    task automatic read_golden();
        int          fd;
        int          cnt;
        string       line;
        golden_op_t  op;
        logic [31:0] c_sel;
        logic [31:0] c_addr;
        logic [31:0] c_rt;
        logic [31:0] c_alu;
        logic [31:0] c_dst;
        logic [31:0] c_wsel;
        logic [31:0] c_hilo;
        logic [31:0] c_hi;
        logic [31:0] c_lo;
        logic [31:0] c_wdata;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_PATH);
            other_err_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 3 || line.substr(0, 1) == "//") begin
                continue;                                // Blank or comment line.
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                          c_sel, c_addr, c_rt, c_alu, c_dst,
                          c_wsel, c_hilo, c_hi, c_lo, c_wdata);
            if (cnt != 10) begin
                $display("Golden file line has %0d columns instead of 10: %s", cnt, line);
                other_err_cnt++;
                continue;
            end
            if (n_ops >= MAX_OPS) begin
                $display("Golden file holds more than %0d operations", MAX_OPS);
                other_err_cnt++;
                break;
            end
            op.ls_sel     = c_sel[3:0];
            op.addr       = c_addr;
            op.rt_data    = c_rt;
            op.alu_res    = c_alu;
            op.w_reg_dst  = c_dst[4:0];
            op.wb_reg_sel = c_wsel[0];
            op.w_hilo_ena = c_hilo[1:0];
            op.hi_res     = c_hi;
            op.lo_res     = c_lo;
            op.w_data     = c_wdata;
            ops[n_ops]    = op;
            n_ops++;
        end
        $fclose(fd);
    endtask

    task automatic make_op_bundle(input golden_op_t op, input int idx,
                                  output mem_stage_pkg::ex_bundle_t b, output expect_t e);
        mem_stage_pkg::ls_sel_e sel;
        logic                   is_mem;
        logic                   is_store;
        sel      = mem_stage_pkg::ls_sel_e'(op.ls_sel);
        is_mem   = (sel != mem_stage_pkg::LS_SEL_NONE);
        is_store = (sel == mem_stage_pkg::LS_SEL_SB) || (sel == mem_stage_pkg::LS_SEL_SH) ||
                   (sel == mem_stage_pkg::LS_SEL_SW);
        b            = '0;
        b.pc         = PC_BASE + idx * 4;
        b.alu_res    = is_mem ? op.addr : op.alu_res;    // ALU result is the address.
        b.rt_data    = op.rt_data;
        b.ls_ena     = is_mem;
        b.ls_sel     = sel;
        b.w_reg_ena  = !is_store;
        b.w_reg_dst  = op.w_reg_dst;
        b.wb_reg_sel = op.wb_reg_sel;
        b.w_hilo_ena = op.w_hilo_ena;
        b.hi_res     = op.hi_res;
        b.lo_res     = op.lo_res;
        e.idle       = 1'b0;
        e.pc         = b.pc;
        e.w_reg_ena  = !is_store;
        e.w_reg_dst  = op.w_reg_dst;
        e.w_data     = op.w_data;
        e.w_hilo_ena = op.w_hilo_ena;
        e.hi_res     = op.hi_res;
        e.lo_res     = op.lo_res;
    endtask

    task automatic check_wb(input expect_t e);
        chk_cnt++;
        assert (wb.w_reg_ena == e.w_reg_ena) else begin
            $display("[FAIL] wb.w_reg_ena expected %h got %h", e.w_reg_ena, wb.w_reg_ena);
            err_cnt++;
        end
        assert (wb.w_hilo_ena == e.w_hilo_ena) else begin
            $display("[FAIL] wb.w_hilo_ena expected %h got %h", e.w_hilo_ena, wb.w_hilo_ena);
            err_cnt++;
        end
        if (!e.idle) begin
            ops_checked++;
            assert (wb.pc == e.pc) else begin
                $display("[FAIL] wb.pc expected %h got %h", e.pc, wb.pc);
                err_cnt++;
            end
            assert (wb.w_reg_dst == e.w_reg_dst) else begin
                $display("[FAIL] wb.w_reg_dst expected %h got %h (pc %h)",
                         e.w_reg_dst, wb.w_reg_dst, e.pc);
                err_cnt++;
            end
            assert (wb.w_data == e.w_data) else begin
                $display("[FAIL] wb.w_data expected %h got %h (pc %h)",
                         e.w_data, wb.w_data, e.pc);
                err_cnt++;
            end
            assert (wb.hi_res == e.hi_res) else begin
                $display("[FAIL] wb.hi_res expected %h got %h (pc %h)", e.hi_res, wb.hi_res, e.pc);
                err_cnt++;
            end
            assert (wb.lo_res == e.lo_res) else begin
                $display("[FAIL] wb.lo_res expected %h got %h (pc %h)", e.lo_res, wb.lo_res, e.pc);
                err_cnt++;
            end
        end
    endtask

    // Result of the slot driven two edges earlier is checked here.
    task automatic drive_slot(input mem_stage_pkg::ex_bundle_t b, input expect_t e);
        @(posedge clk);
        ex <= b;
        exp_q.push_back(e);
        @(negedge clk);
        if (exp_q.size() > 2) begin
            check_wb(exp_q.pop_front());
        end
    endtask

    initial begin
        mem_stage_pkg::ex_bundle_t b;
        mem_stage_pkg::ex_bundle_t rst_ex;
        expect_t                   e;
        expect_t                   idle_exp;
        rst_ex            = '0;
        rst_ex.pc         = PC_BASE;
        rst_ex.w_reg_ena  = 1'b1;                        // Enables held high during reset.
        rst_ex.w_hilo_ena = 2'b11;
        arst_n        = 1'b0;
        ex            = rst_ex;
        n_ops         = 0;
        chk_cnt       = 0;
        ops_checked   = 0;
        err_cnt       = 0;
        other_err_cnt = 0;
        run_started   = 1'b0;
        lfsr_state    = LFSR_SEED;
        idle_exp      = '0;
        idle_exp.idle = 1'b1;
        read_golden();
        if (n_ops == 0) begin
            $display("No operations were read from the golden file");
            other_err_cnt++;
        end
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        ex     <= '0;
        run_started = 1'b1;
        exp_q.push_back(idle_exp);                       // Reset state on wb.
        exp_q.push_back(idle_exp);
        for (int i = 0; i < n_ops; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            if (lfsr_state[0]) begin
                drive_slot('0, idle_exp);
            end
            make_op_bundle(ops[i], i, b, e);
            drive_slot(b, e);
        end
        drive_slot('0, idle_exp);                        // Flush the pipeline.
        drive_slot('0, idle_exp);
        if (ops_checked != n_ops) begin
            $display("Only %0d of %0d operations reached the writeback check",
                     ops_checked, n_ops);
            other_err_cnt++;
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 chk_cnt, err_cnt, other_err_cnt);
        if (err_cnt == 0 && other_err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Two cycles per operation at most plus a margin.
    initial begin
        int limit;
        wait (run_started);
        limit = n_ops * 2 + 20;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles after reset", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/mem_stage_pkg.sv
verilog/ex_mem_reg.sv
verilog/lsu.sv
verilog/data_ram.sv
verilog/writeback_reg.sv
verilog/mem_stage.sv
dv/mem_stage_assert.sv
dv/mem_stage_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mem_stage_tb -f sources.f -o mem_stage_sim \
    && ./obj_dir/mem_stage_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q '^Test OK$' sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- dv/mem_stage_golden.txt
// ls_sel addr rt_data alu_res w_reg_dst wb_reg_sel w_hilo_ena hi_res lo_res exp_w_data
// ls_sel: 0 none 1 lb 2 lbu 3 lh 4 lhu 5 lw 6 sb 7 sh 8 sw, all columns hex
8 00000100 876543a1 00000000 01 0 0 00000000 00000000 00000100
5 00000100 00000000 00000000 02 1 0 11111111 22222222 876543a1
8 00000104 11223344 00000000 03 0 0 00000000 00000000 00000104
6 00000105 abcdef9c 00000000 04 0 0 00000000 00000000 00000105
5 00000104 00000000 00000000 05 1 0 00000000 00000000 11229c44
1 00000105 00000000 00000000 06 1 0 00000000 00000000 ffffff9c
2 00000105 00000000 00000000 07 1 0 00000000 00000000 0000009c
6 00000104 0000007f 00000000 08 0 0 00000000 00000000 00000104
6 00000106 00000080 00000000 09 0 0 00000000 00000000 00000106
6 00000107 000000e1 00000000 0a 0 0 00000000 00000000 00000107
1 00000104 00000000 00000000 0b 1 0 00000000 00000000 0000007f
2 00000104 00000000 00000000 0c 1 0 00000000 00000000 0000007f
1 00000106 00000000 00000000 0d 1 0 00000000 00000000 ffffff80
2 00000106 00000000 00000000 0e 1 0 00000000 00000000 00000080
1 00000107 00000000 00000000 0f 1 0 00000000 00000000 ffffffe1
2 00000107 00000000 00000000 10 1 0 00000000 00000000 000000e1
5 00000104 00000000 00000000 11 1 0 00000000 00000000 e1809c7f
8 00000108 0badf00d 00000000 12 0 0 00000000 00000000 00000108
7 0000010a 5555c3a5 00000000 13 0 0 00000000 00000000 0000010a
7 00000108 12348001 00000000 14 0 0 00000000 00000000 00000108
3 0000010a 00000000 00000000 15 1 0 00000000 00000000 ffffc3a5
4 0000010a 00000000 00000000 16 1 0 00000000 00000000 0000c3a5
3 00000108 00000000 00000000 17 1 0 00000000 00000000 ffff8001
4 00000108 00000000 00000000 18 1 0 00000000 00000000 00008001
5 00000108 00000000 00000000 19 1 0 00000000 00000000 c3a58001
0 00000000 00000000 deadbeef 1f 0 3 12345678 9abcdef0 deadbeef
0 00000000 00000000 00000042 0a 0 1 cafe0001 0000ffff 00000042
0 00000000 00000000 7fffffff 03 0 2 00000010 ffffffff 7fffffff
5 00010100 00000000 00000000 1a 1 1 0000abcd 00001234 876543a1
